/* rtl/decode_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage: fields, format, immediate, alu op, reg reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    fd_if.sink                            fd,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    dx_if.source                          dx
);
    rv_pkg::opcode_t         opcode;
    rv_pkg::inst_fmt_t       fmt;
    rv_pkg::alu_op_t         alu_op;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] inst;

    assign inst     = fd.inst;
    assign opcode   = rv_pkg::opcode_t'(inst[6:0]);  // unnamed codes pass through
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        case (opcode)
            rv_pkg::opc_op:                     fmt = rv_pkg::fmt_r;
            rv_pkg::opc_op_imm, rv_pkg::opc_jalr: fmt = rv_pkg::fmt_i;
            rv_pkg::opc_branch:                 fmt = rv_pkg::fmt_b;
            rv_pkg::opc_lui, rv_pkg::opc_auipc: fmt = rv_pkg::fmt_u;
            rv_pkg::opc_jal:                    fmt = rv_pkg::fmt_j;
            default:                            fmt = rv_pkg::fmt_none;
        endcase
    end

    // sign-extended immediates, b and j keep bit 0 at zero
    always_comb begin
        case (fmt)
            rv_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::fmt_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::fmt_u: imm = {inst[31:12], 12'b0};
            rv_pkg::fmt_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::alu_add;  // address and target sums
        if (opcode == rv_pkg::opc_op || opcode == rv_pkg::opc_op_imm) begin
            case (funct3)
                3'b000: begin
                    // subi does not exist, only the register form subtracts
                    if (fmt == rv_pkg::fmt_r && funct7 == 7'b0100000)
                        alu_op = rv_pkg::alu_sub;
                end
                3'b001: alu_op = rv_pkg::alu_sll;
                3'b010: alu_op = rv_pkg::alu_slt;
                3'b011: alu_op = rv_pkg::alu_sltu;
                3'b100: alu_op = rv_pkg::alu_xor;
                3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110: alu_op = rv_pkg::alu_or;
                default: alu_op = rv_pkg::alu_and;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dx.valid <= 1'b0;
        else
            dx.valid <= fd.valid;
    end

    always_ff @(posedge clk) begin
        if (fd.valid) begin
            dx.pc       <= fd.pc;
            dx.fmt      <= fmt;
            dx.opcode   <= opcode;
            dx.funct3   <= funct3;
            dx.alu_op   <= alu_op;
            dx.rd       <= inst[11:7];
            dx.imm      <= imm;
            dx.rs1_data <= rs1_data;
            dx.rs2_data <= rs2_data;
        end
    end

endmodule

/* rtl/execute_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: operands, alu, branch test and next pc
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module execute_stage (
    input logic  clk,
    input logic  reset,
    dx_if.sink   dx,
    xw_if.source xw
);
    logic [rv_pkg::xlen-1:0] op_a, op_b, alu_y;
    logic [rv_pkg::xlen-1:0] pc4, result, next_pc;
    logic                    taken, is_jal, is_jalr, we;

    assign is_jal  = (dx.opcode == rv_pkg::opc_jal);
    assign is_jalr = (dx.opcode == rv_pkg::opc_jalr);
    assign pc4     = dx.pc + 32'd4;

    always_comb begin
        op_a = dx.rs1_data;
        op_b = (dx.fmt == rv_pkg::fmt_r) ? dx.rs2_data : dx.imm;
        case (dx.opcode)
            rv_pkg::opc_lui: op_a = '0;
            rv_pkg::opc_auipc, rv_pkg::opc_jal, rv_pkg::opc_branch: op_a = dx.pc;
            default: ;
        endcase
    end

    always_comb begin
        case (dx.alu_op)
            rv_pkg::alu_sub:  alu_y = op_a - op_b;
            rv_pkg::alu_sll:  alu_y = op_a << op_b[4:0];
            rv_pkg::alu_slt:  alu_y = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            rv_pkg::alu_sltu: alu_y = (op_a < op_b) ? 32'd1 : 32'd0;
            rv_pkg::alu_xor:  alu_y = op_a ^ op_b;
            rv_pkg::alu_srl:  alu_y = op_a >> op_b[4:0];
            rv_pkg::alu_sra:  alu_y = $signed(op_a) >>> op_b[4:0];
            rv_pkg::alu_or:   alu_y = op_a | op_b;
            rv_pkg::alu_and:  alu_y = op_a & op_b;
            default:          alu_y = op_a + op_b;
        endcase
    end

    // compare uses the register values, the alu builds the target
    always_comb begin
        taken = 1'b0;
        if (dx.opcode == rv_pkg::opc_branch) begin
            case (dx.funct3)
                rv_pkg::f3_beq:  taken = dx.rs1_data == dx.rs2_data;
                rv_pkg::f3_bne:  taken = dx.rs1_data != dx.rs2_data;
                rv_pkg::f3_blt:  taken = $signed(dx.rs1_data) < $signed(dx.rs2_data);
                rv_pkg::f3_bge:  taken = $signed(dx.rs1_data) >= $signed(dx.rs2_data);
                rv_pkg::f3_bltu: taken = dx.rs1_data < dx.rs2_data;
                rv_pkg::f3_bgeu: taken = dx.rs1_data >= dx.rs2_data;
                default:         taken = 1'b0;
            endcase
        end
    end

    assign result = (is_jal || is_jalr) ? pc4 : alu_y;  // link value for jumps

    always_comb begin
        if (is_jalr)
            next_pc = {alu_y[rv_pkg::xlen-1:1], 1'b0};
        else if (is_jal || taken)
            next_pc = alu_y;
        else
            next_pc = pc4;  // also unsupported opcodes
    end

    assign we = (dx.fmt == rv_pkg::fmt_r) || (dx.fmt == rv_pkg::fmt_u) ||
                (dx.fmt == rv_pkg::fmt_j) || (dx.opcode == rv_pkg::opc_op_imm) || is_jalr;

    always_ff @(posedge clk) begin
        if (reset)
            xw.valid <= 1'b0;
        else
            xw.valid <= dx.valid;
    end

    always_ff @(posedge clk) begin
        if (dx.valid) begin
            xw.pc      <= dx.pc;
            xw.rd      <= dx.rd;
            xw.we      <= we;
            xw.result  <= result;
            xw.next_pc <= next_pc;
        end
    end

    a_next_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        dx.valid |=> xw.next_pc[1:0] == 2'b00);

endmodule

/* rtl/fetch_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage: pc register, one request per retire, capture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pc_load,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic                    imem_valid,
    input  logic [rv_pkg::xlen-1:0] imem_rdata,
    output logic                    imem_req,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    fd_if.source                    fd
);
    typedef enum logic {
        idle,
        waiting
    } fetch_state_t;

    fetch_state_t            state;
    logic [rv_pkg::xlen-1:0] pc;
    logic                    boot;    // first request after reset still owed
    logic                    accept;

    assign accept    = (state == waiting) && imem_valid;
    assign imem_addr = pc;  // only moves on pc_load, so stable while waiting

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            pc       <= rv_pkg::reset_pc;
            boot     <= 1'b1;
            imem_req <= 1'b0;
            fd.valid <= 1'b0;
        end else begin
            boot     <= 1'b0;
            imem_req <= 1'b0;
            fd.valid <= accept;
            if (pc_load)
                pc <= next_pc;
            if (boot || pc_load) begin
                imem_req <= 1'b1;  // request goes out with the new pc
                state    <= waiting;
            end else if (accept) begin
                state <= idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fd.pc   <= pc;
            fd.inst <= imem_rdata;
        end
    end

    // a new request only leaves from idle, never with one outstanding
    a_req_from_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(imem_req) |-> $past(state) == idle);

    // memory answers only to an outstanding request
    a_valid_in_wait: assert property (@(posedge clk) disable iff (reset)
        imem_valid |-> state == waiting);

endmodule

/* rtl/reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file: 32 x 32, two async reads, one write, x0 = 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          wen,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata
);
    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 storage is cleared on reset and never written, so it reads as zero
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // a write aimed at x0 must not show up on either read port
    a_x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        (wen && waddr == '0) |=>
            (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0));

endmodule

/* rtl/rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i multicycle core: fetch, decode, execute, writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rv_core (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          imem_req,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  logic                          imem_valid,
    input  logic [rv_pkg::xlen-1:0]       imem_rdata,
    output logic                          retire_valid,
    output logic [rv_pkg::xlen-1:0]       retire_pc,
    output logic                          retire_we,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_wdata
);
    fd_if fd_bus ();
    dx_if dx_bus ();
    xw_if xw_bus ();

    logic                          pc_load;
    logic [rv_pkg::xlen-1:0]       next_pc;
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr, waddr;
    logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data, wdata;
    logic                          wen;

    fetch_stage u_fetch (
        .clk        (clk),
        .reset      (reset),
        .pc_load    (pc_load),
        .next_pc    (next_pc),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .fd         (fd_bus)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .fd       (fd_bus),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dx       (dx_bus)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (wen),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    execute_stage u_execute (
        .clk   (clk),
        .reset (reset),
        .dx    (dx_bus),
        .xw    (xw_bus)
    );

    writeback_stage u_writeback (
        .xw           (xw_bus),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .pc_load      (pc_load),
        .next_pc      (next_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

endmodule

/* rtl/rv_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i core package: widths, reset pc and decode encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // major opcodes the core executes, anything else retires as a no-op
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

/* rtl/stage_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage links: one instruction handed between adjacent stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface fd_if;
    logic                    valid;  // one-cycle pulse
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] inst;

    modport source (output valid, pc, inst);
    modport sink (input valid, pc, inst);
endinterface

interface dx_if;
    logic                          valid;
    logic [rv_pkg::xlen-1:0]       pc;
    rv_pkg::inst_fmt_t             fmt;
    rv_pkg::opcode_t               opcode;
    logic [2:0]                    funct3;
    rv_pkg::alu_op_t               alu_op;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;

    modport source (output valid, pc, fmt, opcode, funct3, alu_op, rd, imm, rs1_data, rs2_data);
    modport sink (input valid, pc, fmt, opcode, funct3, alu_op, rd, imm, rs1_data, rs2_data);
endinterface

interface xw_if;
    logic                          valid;
    logic [rv_pkg::xlen-1:0]       pc;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic                          we;      // instruction writes rd
    logic [rv_pkg::xlen-1:0]       result;
    logic [rv_pkg::xlen-1:0]       next_pc;

    modport source (output valid, pc, rd, we, result, next_pc);
    modport sink (input valid, pc, rd, we, result, next_pc);
endinterface

/* rtl/writeback_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback: commits register write, pc redirect and retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module writeback_stage (
    xw_if.sink                            xw,
    output logic                          wen,
    output logic [rv_pkg::reg_addr_w-1:0] waddr,
    output logic [rv_pkg::xlen-1:0]       wdata,
    output logic                          pc_load,
    output logic [rv_pkg::xlen-1:0]       next_pc,
    output logic                          retire_valid,
    output logic [rv_pkg::xlen-1:0]       retire_pc,
    output logic                          retire_we,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_wdata
);
    // register write, x0 is filtered in the register file
    assign wen   = xw.valid && xw.we;
    assign waddr = xw.rd;
    assign wdata = xw.result;

    // every retire redirects fetch, even to pc+4
    assign pc_load = xw.valid;
    assign next_pc = xw.next_pc;

    assign retire_valid = xw.valid;
    assign retire_pc    = xw.pc;
    assign retire_we    = xw.valid && xw.we;
    assign retire_rd    = xw.rd;
    assign retire_wdata = xw.result;

endmodule

/* run.sh */
#!/bin/sh
# build the rv_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f sim.f -o tb_rv_core \
    && ./obj_dir/tb_rv_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* sim.f */
+incdir+include
rtl/rv_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/rv_core.sv
sim/tb_rv_core.sv

/* include/tb_program.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv_core test program and its expected retire sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// word i sits at address 8000_0000 + 4*i
localparam int prog_len = 45;
localparam logic [31:0] prog_words [prog_len] = '{
    32'h002081b3, 32'h00500093, 32'hffd00113, 32'h00208233, 32'h402082b3, // add..sub
    32'h00409313, 32'h001093b3, 32'h00112433, 32'hffc12493, 32'h0020b533, // shifts, slt
    32'h0020c5b3, 32'h00115633, 32'h40115693, 32'h0020e733, 32'h0020f7b3, // logic ops
    32'h12345837, 32'h00001897, 32'h00708013, 32'h00000933, 32'h00108463, // lui, x0
    32'h00100993, 32'h00109463, 32'h00209463, 32'h00100993, 32'h00114463,
    32'h00100993, 32'h0020c463, 32'h0020d463, 32'h00100993, 32'h00115463,
    32'h0020e463, 32'h00100993, 32'h00116463, 32'h00117463, 32'h00100993,
    32'h0020f463, 32'h00208463, 32'h00800a6f, 32'h00100993, 32'h00000a97, // jal
    32'h00da8b67, 32'h00100993, 32'h414b0bb3, 32'h00000073, 32'hfff08c13  // jalr, ecall
};

// row is {pc, we, rd, wdata}, rd and wdata are zero where we is low
localparam int exp_len = 37;
localparam logic [69:0] exp_rows [exp_len] = '{
    {32'h80000000, 1'b1, 5'd3, 32'h00000000}, {32'h80000004, 1'b1, 5'd1, 32'h00000005},
    {32'h80000008, 1'b1, 5'd2, 32'hfffffffd}, {32'h8000000c, 1'b1, 5'd4, 32'h00000002},
    {32'h80000010, 1'b1, 5'd5, 32'h00000008}, {32'h80000014, 1'b1, 5'd6, 32'h00000050},
    {32'h80000018, 1'b1, 5'd7, 32'h000000a0}, {32'h8000001c, 1'b1, 5'd8, 32'h00000001},
    {32'h80000020, 1'b1, 5'd9, 32'h00000000}, {32'h80000024, 1'b1, 5'd10, 32'h00000001},
    {32'h80000028, 1'b1, 5'd11, 32'hfffffff8}, {32'h8000002c, 1'b1, 5'd12, 32'h07ffffff},
    {32'h80000030, 1'b1, 5'd13, 32'hfffffffe}, {32'h80000034, 1'b1, 5'd14, 32'hfffffffd},
    {32'h80000038, 1'b1, 5'd15, 32'h00000005}, {32'h8000003c, 1'b1, 5'd16, 32'h12345000},
    {32'h80000040, 1'b1, 5'd17, 32'h80001040}, {32'h80000044, 1'b1, 5'd0, 32'h0000000c},
    {32'h80000048, 1'b1, 5'd18, 32'h00000000}, {32'h8000004c, 1'b0, 5'd0, 32'h00000000},
    {32'h80000054, 1'b0, 5'd0, 32'h00000000}, {32'h80000058, 1'b0, 5'd0, 32'h00000000},
    {32'h80000060, 1'b0, 5'd0, 32'h00000000}, {32'h80000068, 1'b0, 5'd0, 32'h00000000},
    {32'h8000006c, 1'b0, 5'd0, 32'h00000000}, {32'h80000074, 1'b0, 5'd0, 32'h00000000},
    {32'h80000078, 1'b0, 5'd0, 32'h00000000}, {32'h80000080, 1'b0, 5'd0, 32'h00000000},
    {32'h80000084, 1'b0, 5'd0, 32'h00000000}, {32'h8000008c, 1'b0, 5'd0, 32'h00000000},
    {32'h80000090, 1'b0, 5'd0, 32'h00000000}, {32'h80000094, 1'b1, 5'd20, 32'h80000098},
    {32'h8000009c, 1'b1, 5'd21, 32'h8000009c}, {32'h800000a0, 1'b1, 5'd22, 32'h800000a4},
    {32'h800000a8, 1'b1, 5'd23, 32'h0000000c}, {32'h800000ac, 1'b0, 5'd0, 32'h00000000},
    {32'h800000b0, 1'b1, 5'd24, 32'h00000004}
};

`endif

/* sim/tb_rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv_core testbench: fetch memory with random latency,
// every retire compared against the expected table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_rv_core;

    `include "tb_program.svh"

    localparam int req_limit    = 40;  // cycles allowed until a fetch request
    localparam int retire_limit = 12;

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;

    int errors;
    int timeouts;
    bit stop;

    rv_core DUT (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

    always #10 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one instruction from request to retire
    task automatic run_row(input int r);
        logic [69:0] row;
        logic [31:0] req_addr;
        int          idx;
        int          n;
        int          delay;
        bit          seen;
        row  = exp_rows[r];
        n    = 0;
        seen = 1'b0;
        while (!seen && n < req_limit) begin
            @(posedge clk);
            #2;
            seen = imem_req;
            n++;
        end
        assert (seen) else begin
            timeouts++;
            stop = 1'b1;
            $display("timeout: no fetch request arrived for retire row %0d", r);
        end
        if (stop)
            return;

        req_addr = imem_addr;
        compare_value("imem_addr", req_addr, row[69:38]);
        delay = $urandom_range(3, 0);  // memory latency
        repeat (delay) begin
            @(posedge clk);
            #2;
        end
        compare_value("imem_addr", imem_addr, req_addr);  // held while waiting

        idx = int'((req_addr - 32'h8000_0000) >> 2);
        assert (idx >= 0 && idx < prog_len) else begin
            errors++;
            $display("fetch address %h lies outside the test program", req_addr);
        end
        imem_valid = 1'b1;
        imem_rdata = (idx >= 0 && idx < prog_len) ? prog_words[idx] : 32'h0000_0013;

        n    = 0;
        seen = 1'b0;
        while (!seen && n < retire_limit) begin
            @(posedge clk);
            #2;
            imem_valid = 1'b0;
            n++;
            seen = retire_valid;
        end
        assert (seen) else begin
            timeouts++;
            stop = 1'b1;
            $display("timeout: instruction at %h never retired", req_addr);
        end
        if (stop)
            return;

        compare_value("retire_valid cycles", n, 3);
        compare_value("retire_pc", retire_pc, row[69:38]);
        compare_value("retire_we", retire_we, row[37]);
        if (row[37]) begin
            compare_value("retire_rd", retire_rd, row[36:32]);
            compare_value("retire_wdata", retire_wdata, row[31:0]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        errors     = 0;
        timeouts   = 0;
        stop       = 1'b0;
        void'($urandom(88));

        repeat (4) begin
            @(posedge clk);
            #2;
            assert (imem_req === 1'b0 && retire_valid === 1'b0) else begin
                errors++;
                $display("imem_req or retire_valid was not low during reset");
            end
        end
        reset = 1'b0;

        for (int r = 0; r < exp_len && !stop; r++)
            run_row(r);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
